//--- design/floppy_pkg.sv
`default_nettype none

package floppy_pkg;

	typedef logic [15:0] wh_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [8:0]  buf_addr_t;
	typedef logic [2:0]  host_addr_t;

	// io port offsets from the io base
	localparam wh_addr_t PORT_MMCA        = 16'd0;
	localparam wh_addr_t PORT_SPDR        = 16'd1;
	localparam wh_addr_t PORT_SPSR        = 16'd2;
	localparam wh_addr_t PORT_TXD         = 16'd4;
	localparam wh_addr_t PORT_CTL         = 16'd6;
	localparam wh_addr_t PORT_TMR1        = 16'd7;
	localparam wh_addr_t PORT_TMR2        = 16'd8;
	localparam wh_addr_t PORT_CPU_REQUEST = 16'd9;
	localparam wh_addr_t PORT_CPU_STATUS  = 16'd10;
	localparam wh_addr_t PORT_TRACK       = 16'd11;
	localparam wh_addr_t PORT_SECTOR      = 16'd12;

	// workhorse window onto the sector buffer
	localparam wh_addr_t BUF_BASE = 16'h0200;
	localparam wh_addr_t BUF_TOP  = 16'h0400;

	// wd1793 register selects as seen by the host
	localparam host_addr_t HREG_DATA   = 3'd0;
	localparam host_addr_t HREG_SECTOR = 3'd1;
	localparam host_addr_t HREG_TRACK  = 3'd2;
	localparam host_addr_t HREG_CMD    = 3'd3;
	localparam host_addr_t HREG_CTL    = 3'd4;

	localparam int STAT_BUSY = 0;
	localparam int STAT_DRQ  = 1;

	// command classes by top nibble
	localparam logic [3:0] CMD_READ_SECTOR  = 4'h8;
	localparam logic [3:0] CMD_WRITE_SECTOR = 4'hA;

	typedef enum logic [1:0] {IDLE, HOST_FILL, POSTED, HOST_DRAIN} fdc_state_t;

endpackage

`default_nettype wire

//--- design/sector_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module sector_buffer (
	input  logic                  clk,
	input  logic                  en,
	input  floppy_pkg::buf_addr_t addr,
	input  logic                  wr,
	input  floppy_pkg::byte_t     wdata,
	output floppy_pkg::byte_t     rdata
);

	floppy_pkg::byte_t mem [512];

	// read returns the old contents on a write cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (wr)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- design/fdc_host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fdc_host_regs #(
	parameter int SECTOR_BYTES = 256
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  floppy_pkg::host_addr_t host_addr,
	input  floppy_pkg::byte_t      host_wdata,
	input  logic                   host_rd,
	input  logic                   host_wr,
	output floppy_pkg::byte_t      host_rdata,
	output floppy_pkg::buf_addr_t  buff_addr,
	output logic                   buff_rd,
	output logic                   buff_wr,
	output floppy_pkg::byte_t      buff_wdata,
	input  floppy_pkg::byte_t      buff_rdata,
	output floppy_pkg::byte_t      cpu_request,
	output floppy_pkg::byte_t      track,
	output floppy_pkg::byte_t      sector,
	input  logic                   status_wr,
	input  floppy_pkg::byte_t      status_data
);

	localparam logic [9:0] LAST_FILL = 10'(SECTOR_BYTES - 1);
	localparam logic [9:0] DRAIN_END = 10'(SECTOR_BYTES);

	floppy_pkg::fdc_state_t state;
	floppy_pkg::byte_t data_reg;
	floppy_pkg::byte_t cmd_reg;
	floppy_pkg::byte_t status;
	logic [9:0] ptr;
	logic prefetch;
	logic rd_pend;
	logic data_wr, data_rd, cmd_wr;

	assign data_wr = host_wr && (host_addr == floppy_pkg::HREG_DATA);
	assign data_rd = host_rd && (host_addr == floppy_pkg::HREG_DATA);
	assign cmd_wr  = host_wr && (host_addr == floppy_pkg::HREG_CMD);

	// host register read mux
	always_comb begin
		case (host_addr)
			floppy_pkg::HREG_DATA:   host_rdata = data_reg;
			floppy_pkg::HREG_SECTOR: host_rdata = sector;
			floppy_pkg::HREG_TRACK:  host_rdata = track;
			floppy_pkg::HREG_CMD:    host_rdata = status;
			default:                 host_rdata = 8'hFF;
		endcase
	end

	// fill stores at ptr and drain fetches at ptr
	assign buff_addr  = ptr[8:0];
	assign buff_wdata = host_wdata;
	assign buff_wr    = (state == floppy_pkg::HOST_FILL) && data_wr;
	assign buff_rd    = prefetch ||
		((state == floppy_pkg::HOST_DRAIN) && data_rd && (ptr != DRAIN_END));

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= floppy_pkg::IDLE;
			ptr <= '0;
			prefetch <= 1'b0;
			rd_pend <= 1'b0;
			cpu_request <= '0;
			status <= '0;
		end else begin
			rd_pend <= buff_rd;
			prefetch <= 1'b0;
			if (buff_rd)
				ptr <= ptr + 1'b1;
			case (state)
				floppy_pkg::IDLE: begin
					if (cmd_wr) begin
						status <= '0;
						status[floppy_pkg::STAT_BUSY] <= 1'b1;
						ptr <= '0;
						if (host_wdata[7:4] == floppy_pkg::CMD_WRITE_SECTOR) begin
							status[floppy_pkg::STAT_DRQ] <= 1'b1;
							state <= floppy_pkg::HOST_FILL;
						end else begin
							// reads and everything else go straight out
							cpu_request <= host_wdata;
							state <= floppy_pkg::POSTED;
						end
					end
				end
				floppy_pkg::HOST_FILL: begin
					if (data_wr) begin
						ptr <= ptr + 1'b1;
						if (ptr == LAST_FILL) begin
							status[floppy_pkg::STAT_DRQ] <= 1'b0;
							cpu_request <= cmd_reg;
							state <= floppy_pkg::POSTED;
						end
					end
				end
				floppy_pkg::POSTED: begin
					if (status_wr) begin
						cpu_request <= '0;
						status <= status_data;
						status[floppy_pkg::STAT_BUSY] <= 1'b0;
						status[floppy_pkg::STAT_DRQ] <= 1'b0;
						if (cmd_reg[7:4] == floppy_pkg::CMD_READ_SECTOR) begin
							ptr <= '0;
							prefetch <= 1'b1;
							state <= floppy_pkg::HOST_DRAIN;
						end else begin
							state <= floppy_pkg::IDLE;
						end
					end
				end
				floppy_pkg::HOST_DRAIN: begin
					// drq comes up once the first byte lands
					if (rd_pend)
						status[floppy_pkg::STAT_DRQ] <= 1'b1;
					if (data_rd && (ptr == DRAIN_END)) begin
						status[floppy_pkg::STAT_DRQ] <= 1'b0;
						state <= floppy_pkg::IDLE;
					end
				end
				default: state <= floppy_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (host_wr) begin
			case (host_addr)
				floppy_pkg::HREG_TRACK:  track <= host_wdata;
				floppy_pkg::HREG_SECTOR: sector <= host_wdata;
				floppy_pkg::HREG_DATA:   data_reg <= host_wdata;
				default: ;
			endcase
		end
		if (cmd_wr && (state == floppy_pkg::IDLE))
			cmd_reg <= host_wdata;
		if (rd_pend)
			data_reg <= buff_rdata;
	end

	assert property (@(posedge clk) disable iff (!reset_n) !(buff_rd && buff_wr));

endmodule

`default_nettype wire

//--- design/spi_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master #(
	parameter int SPI_DIV = 4
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              start,
	input  floppy_pkg::byte_t wdata,
	input  logic              miso,
	output floppy_pkg::byte_t rdata,
	output logic              busy,
	output logic              sck,
	output logic              mosi
);

	localparam int DW = $clog2(SPI_DIV + 1);

	logic [DW-1:0] div_cnt;
	logic [3:0] edge_cnt;
	logic half_done;
	floppy_pkg::byte_t shreg;
	logic miso_q;

	assign half_done = (div_cnt == DW'(SPI_DIV - 1));

	// 16 sck edges per byte, busy drops on the last falling one
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy <= 1'b0;
			sck <= 1'b0;
			mosi <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= '0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				div_cnt <= '0;
				edge_cnt <= '0;
				mosi <= wdata[7];
			end
		end else if (half_done) begin
			div_cnt <= '0;
			sck <= ~sck;
			edge_cnt <= edge_cnt + 1'b1;
			if (sck) begin
				if (edge_cnt == 4'd15)
					busy <= 1'b0;
				else
					mosi <= shreg[6];
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// sample on rising sck, shift on falling
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			shreg <= wdata;
		end else if (busy && half_done) begin
			if (!sck) begin
				miso_q <= miso;
			end else begin
				shreg <= {shreg[6:0], miso_q};
				if (edge_cnt == 4'd15)
					rdata <= {shreg[6:0], miso_q};
			end
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n) !busy |-> !sck);

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
	parameter int BAUD_DIV = 434
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              start,
	input  floppy_pkg::byte_t data,
	output logic              txd,
	output logic              busy
);

	localparam int BW = $clog2(BAUD_DIV + 1);

	logic [BW-1:0] baud_cnt;
	logic [3:0] bit_idx;
	logic [8:0] shreg;
	logic bit_done;

	assign bit_done = (baud_cnt == BW'(BAUD_DIV - 1));

	// frame is start bit, 8 data bits lsb first, stop bit
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy <= 1'b0;
			txd <= 1'b1;
			baud_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				txd <= 1'b0;
				baud_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (bit_done) begin
			baud_cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
				txd <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				txd <= shreg[0];
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// data bits then the stop bit
	always_ff @(posedge clk) begin
		if (!busy && start)
			shreg <= {1'b1, data};
		else if (busy && bit_done)
			shreg <= {1'b1, shreg[8:1]};
	end

	assert property (@(posedge clk) disable iff (!reset_n) !busy |-> txd);

endmodule

`default_nettype wire

//--- design/tick_timer.sv
`timescale 1ns/1ns
`default_nettype none

module tick_timer #(
	parameter int TICK_DIV = 500000
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              load,
	input  floppy_pkg::byte_t value,
	output floppy_pkg::byte_t count
);

	localparam int PW = $clog2(TICK_DIV + 1);

	logic [PW-1:0] prescale;
	logic tick;

	assign tick = (prescale == PW'(TICK_DIV - 1));

	// loading restarts the prescaler, counter holds at zero
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			prescale <= '0;
			count <= '0;
		end else if (load) begin
			prescale <= '0;
			count <= value;
		end else begin
			prescale <= tick ? '0 : prescale + 1'b1;
			if (tick && (count != 8'h00))
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/floppy_controller.sv
`timescale 1ns/1ns
`default_nettype none

module floppy_controller #(
	parameter floppy_pkg::wh_addr_t IO_BASE = 16'hE000,
	parameter int TICK_DIV     = 500000,
	parameter int SPI_DIV      = 4,
	parameter int BAUD_DIV     = 434,
	parameter int SECTOR_BYTES = 256
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   ce,
	input  floppy_pkg::wh_addr_t   wh_addr,
	input  floppy_pkg::byte_t      wh_wdata,
	input  logic                   wh_wr,
	output floppy_pkg::byte_t      wh_rdata,
	input  floppy_pkg::host_addr_t host_addr,
	input  floppy_pkg::byte_t      host_wdata,
	input  logic                   host_rd,
	input  logic                   host_wr,
	output floppy_pkg::byte_t      host_rdata,
	output logic                   sd_cs,
	output logic                   sd_clk,
	output logic                   sd_mosi,
	input  logic                   sd_miso,
	output logic                   uart_txd
);

	logic wr_en;
	logic buf_sel;
	logic buf_rd_q;
	floppy_pkg::wh_addr_t wh_buf_off;
	floppy_pkg::byte_t io_mux;
	floppy_pkg::byte_t io_q;

	logic spi_start, spi_busy;
	floppy_pkg::byte_t spdr;
	logic uart_start, uart_busy;
	logic tmr1_load, tmr2_load;
	floppy_pkg::byte_t tmr1, tmr2;

	logic status_wr;
	floppy_pkg::byte_t status_data;
	floppy_pkg::byte_t cpu_request, track, sector;

	floppy_pkg::buf_addr_t buff_addr;
	logic buff_rd, buff_wr;
	floppy_pkg::byte_t buff_wdata;
	logic fdc_acc;
	logic buf_en, buf_wr;
	floppy_pkg::buf_addr_t buf_addr;
	floppy_pkg::byte_t buf_wdata, buf_rdata;

	//////////////////////////////
	// address decode and write strobes
	//////////////////////////////
	assign wr_en = ce & wh_wr;
	assign buf_sel = (wh_addr >= floppy_pkg::BUF_BASE) && (wh_addr < floppy_pkg::BUF_TOP);
	assign wh_buf_off = wh_addr - floppy_pkg::BUF_BASE;

	assign spi_start  = wr_en && (wh_addr == IO_BASE + floppy_pkg::PORT_SPDR);
	assign uart_start = wr_en && (wh_addr == IO_BASE + floppy_pkg::PORT_TXD);
	assign tmr1_load  = wr_en && (wh_addr == IO_BASE + floppy_pkg::PORT_TMR1);
	assign tmr2_load  = wr_en && (wh_addr == IO_BASE + floppy_pkg::PORT_TMR2);

	// card select latch and status return strobe
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sd_cs <= 1'b1;
			status_wr <= 1'b0;
		end else begin
			if (wr_en && (wh_addr == IO_BASE + floppy_pkg::PORT_MMCA))
				sd_cs <= wh_wdata[0];
			status_wr <= wr_en && (wh_addr == IO_BASE + floppy_pkg::PORT_CPU_STATUS);
		end
	end

	always_ff @(posedge clk) begin
		status_data <= wh_wdata;
	end

	//////////////////////////////
	// workhorse read path
	//////////////////////////////
	always_comb begin
		case (wh_addr)
			IO_BASE + floppy_pkg::PORT_SPSR:        io_mux = {7'b0, spi_busy};
			IO_BASE + floppy_pkg::PORT_CTL:         io_mux = {7'b0, uart_busy};
			IO_BASE + floppy_pkg::PORT_TMR1:        io_mux = tmr1;
			IO_BASE + floppy_pkg::PORT_TMR2:        io_mux = tmr2;
			IO_BASE + floppy_pkg::PORT_SPDR:        io_mux = spdr;
			IO_BASE + floppy_pkg::PORT_CPU_REQUEST: io_mux = cpu_request;
			IO_BASE + floppy_pkg::PORT_TRACK:       io_mux = track;
			IO_BASE + floppy_pkg::PORT_SECTOR:      io_mux = sector;
			default:                                io_mux = 8'hFF;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			buf_rd_q <= 1'b0;
		else if (ce)
			buf_rd_q <= buf_sel;
	end

	always_ff @(posedge clk) begin
		if (ce)
			io_q <= io_mux;
	end

	// buffer data is already registered inside the ram
	assign wh_rdata = buf_rd_q ? buf_rdata : io_q;

	//////////////////////////////
	// buffer arbitration
	//////////////////////////////
	assign fdc_acc   = buff_rd | buff_wr;
	assign buf_en    = fdc_acc | (ce & buf_sel);
	assign buf_addr  = fdc_acc ? buff_addr : wh_buf_off[8:0];
	assign buf_wr    = fdc_acc ? buff_wr : wh_wr;
	assign buf_wdata = fdc_acc ? buff_wdata : wh_wdata;

	// fdc only uses the buffer with no request out, and never with the workhorse
	assert property (@(posedge clk) disable iff (!reset_n)
		fdc_acc |-> (cpu_request == 8'h00) && !(ce && buf_sel));

	sector_buffer u_buffer (
		.clk   (clk),
		.en    (buf_en),
		.addr  (buf_addr),
		.wr    (buf_wr),
		.wdata (buf_wdata),
		.rdata (buf_rdata)
	);

	fdc_host_regs #(.SECTOR_BYTES(SECTOR_BYTES)) u_fdc (
		.clk         (clk),
		.reset_n     (reset_n),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_rd     (host_rd),
		.host_wr     (host_wr),
		.host_rdata  (host_rdata),
		.buff_addr   (buff_addr),
		.buff_rd     (buff_rd),
		.buff_wr     (buff_wr),
		.buff_wdata  (buff_wdata),
		.buff_rdata  (buf_rdata),
		.cpu_request (cpu_request),
		.track       (track),
		.sector      (sector),
		.status_wr   (status_wr),
		.status_data (status_data)
	);

	spi_master #(.SPI_DIV(SPI_DIV)) u_spi (
		.clk     (clk),
		.reset_n (reset_n),
		.start   (spi_start),
		.wdata   (wh_wdata),
		.miso    (sd_miso),
		.rdata   (spdr),
		.busy    (spi_busy),
		.sck     (sd_clk),
		.mosi    (sd_mosi)
	);

	uart_tx #(.BAUD_DIV(BAUD_DIV)) u_uart (
		.clk     (clk),
		.reset_n (reset_n),
		.start   (uart_start),
		.data    (wh_wdata),
		.txd     (uart_txd),
		.busy    (uart_busy)
	);

	tick_timer #(.TICK_DIV(TICK_DIV)) u_timer1 (
		.clk     (clk),
		.reset_n (reset_n),
		.load    (tmr1_load),
		.value   (wh_wdata),
		.count   (tmr1)
	);

	tick_timer #(.TICK_DIV(TICK_DIV)) u_timer2 (
		.clk     (clk),
		.reset_n (reset_n),
		.load    (tmr2_load),
		.value   (wh_wdata),
		.count   (tmr2)
	);

endmodule

`default_nettype wire

//--- testbench/floppy_tb.sv
`timescale 1ns/1ns
`default_nettype none

module floppy_tb;

	localparam floppy_pkg::wh_addr_t IO_BASE = 16'hE000;
	localparam int TICK_DIV     = 4;
	localparam int BAUD_DIV     = 8;
	localparam int SECTOR_BYTES = 16;
	localparam int POLL_LIMIT   = 500;

	logic clk;
	logic reset_n;
	logic ce;
	floppy_pkg::wh_addr_t wh_addr;
	floppy_pkg::byte_t wh_wdata;
	logic wh_wr;
	floppy_pkg::byte_t wh_rdata;
	floppy_pkg::host_addr_t host_addr;
	floppy_pkg::byte_t host_wdata;
	logic host_rd;
	logic host_wr;
	floppy_pkg::byte_t host_rdata;
	logic sd_cs, sd_clk, sd_mosi, uart_txd;

	integer seed = 74473;
	floppy_pkg::byte_t fill [SECTOR_BYTES];

	// miso looped back onto mosi
	floppy_controller #(
		.IO_BASE(IO_BASE), .TICK_DIV(TICK_DIV), .SPI_DIV(4),
		.BAUD_DIV(BAUD_DIV), .SECTOR_BYTES(SECTOR_BYTES)
	) i_floppy_controller (
		.clk(clk), .reset_n(reset_n), .ce(ce),
		.wh_addr(wh_addr), .wh_wdata(wh_wdata), .wh_wr(wh_wr), .wh_rdata(wh_rdata),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rd(host_rd),
		.host_wr(host_wr), .host_rdata(host_rdata),
		.sd_cs(sd_cs), .sd_clk(sd_clk), .sd_mosi(sd_mosi), .sd_miso(sd_mosi),
		.uart_txd(uart_txd)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// checking helpers
	//////////////////////////////
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input floppy_pkg::byte_t expected,
			input floppy_pkg::byte_t actual);
		assert (expected == actual)
			else abort_run($sformatf("Fail %s: expected 0x%h, actual 0x%h",
				test, expected, actual));
	endtask

	// chip select only moves on an mmca write
	assert property (@(posedge clk) disable iff (!reset_n)
		!(ce && wh_wr && wh_addr == IO_BASE + floppy_pkg::PORT_MMCA) |=> $stable(sd_cs))
		else abort_run("sd_cs changed without a write to MMCA");

	assert property (@(posedge clk) disable iff (!reset_n) $rose(sd_clk) |-> !sd_cs)
		else abort_run("sd_clk toggled while the card was not selected");

	//////////////////////////////
	// bus tasks
	//////////////////////////////
	task automatic wh_write(input floppy_pkg::wh_addr_t addr, input floppy_pkg::byte_t data);
		wh_addr = addr;
		wh_wdata = data;
		wh_wr = 1'b1;
		ce = 1'b1;
		@(posedge clk);
		#1;
		ce = 1'b0;
		wh_wr = 1'b0;
	endtask

	// registered read with the data there one edge later
	task automatic wh_read(input floppy_pkg::wh_addr_t addr, output floppy_pkg::byte_t data);
		wh_addr = addr;
		wh_wr = 1'b0;
		ce = 1'b1;
		@(posedge clk);
		#1;
		ce = 1'b0;
		data = wh_rdata;
	endtask

	task automatic host_write(input floppy_pkg::host_addr_t addr, input floppy_pkg::byte_t data);
		host_addr = addr;
		host_wdata = data;
		host_wr = 1'b1;
		@(posedge clk);
		#1;
		host_wr = 1'b0;
	endtask

	task automatic host_read(input floppy_pkg::host_addr_t addr, output floppy_pkg::byte_t data);
		host_addr = addr;
		host_rd = 1'b1;
		#1;
		data = host_rdata;
		@(posedge clk);
		#1;
		host_rd = 1'b0;
	endtask

	// next byte lands two cycles after the strobe
	task automatic host_read_data(output floppy_pkg::byte_t data);
		host_read(floppy_pkg::HREG_DATA, data);
		repeat (2) @(posedge clk);
		#1;
	endtask

	//////////////////////////////
	// polling with timeouts
	//////////////////////////////
	task automatic wait_io_clear(input floppy_pkg::wh_addr_t addr, input string what);
		floppy_pkg::byte_t v;
		int n;
		n = 0;
		do begin
			wh_read(addr, v);
			n++;
			if (n > POLL_LIMIT)
				abort_run($sformatf("timed out waiting for %s to clear", what));
		end while (v[0]);
	endtask

	task automatic wait_request(output floppy_pkg::byte_t req);
		int n;
		n = 0;
		do begin
			wh_read(IO_BASE + floppy_pkg::PORT_CPU_REQUEST, req);
			n++;
			if (n > POLL_LIMIT)
				abort_run("timed out waiting for a request from the host side");
		end while (req == 8'h00);
	endtask

	task automatic wait_host_status(input floppy_pkg::byte_t mask, input floppy_pkg::byte_t value,
			input string what);
		floppy_pkg::byte_t v;
		int n;
		n = 0;
		do begin
			host_read(floppy_pkg::HREG_CMD, v);
			n++;
			if (n > POLL_LIMIT)
				abort_run($sformatf("timed out waiting for host status: %s", what));
		end while ((v & mask) != value);
	endtask

	// mid-bit sampling of one 8N1 frame
	task automatic decode_uart(output floppy_pkg::byte_t data);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
			if (n > POLL_LIMIT)
				abort_run("timed out waiting for a uart start bit");
		end while (uart_txd);
		repeat (BAUD_DIV / 2) @(posedge clk);
		#1;
		check_value("uart start bit", 8'h00, {7'b0, uart_txd});
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_DIV) @(posedge clk);
			#1;
			data[i] = uart_txd;
		end
		repeat (BAUD_DIV) @(posedge clk);
		#1;
		check_value("uart stop bit", 8'h01, {7'b0, uart_txd});
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		floppy_pkg::byte_t b, v, rx, req, trk, sec, n1, t2;
		int elapsed;

		reset_n = 1'b0;
		ce = 1'b0;
		wh_addr = '0;
		wh_wdata = '0;
		wh_wr = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_rd = 1'b0;
		host_wr = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// reset and idle
		check_value("reset sd_cs", 8'h01, {7'b0, sd_cs});
		check_value("reset sd_clk", 8'h00, {7'b0, sd_clk});
		check_value("reset sd_mosi", 8'h00, {7'b0, sd_mosi});
		check_value("reset uart_txd", 8'h01, {7'b0, uart_txd});
		wh_read(IO_BASE + floppy_pkg::PORT_CPU_REQUEST, v);
		check_value("reset request", 8'h00, v);
		host_read(floppy_pkg::HREG_CMD, v);
		check_value("reset status", 8'h00, v);
		wh_read(IO_BASE + floppy_pkg::PORT_SPSR, v);
		check_value("reset spi busy", 8'h00, v);
		wh_read(IO_BASE + floppy_pkg::PORT_CTL, v);
		check_value("reset uart busy", 8'h00, v);
		wh_read(IO_BASE + 16'd3, v);
		check_value("unmapped port", 8'hFF, v);
		wh_read(16'h1234, v);
		check_value("unmapped address", 8'hFF, v);

		// spi loopback with the card selected
		wh_write(IO_BASE + floppy_pkg::PORT_MMCA, 8'h00);
		check_value("card select low", 8'h00, {7'b0, sd_cs});
		b = 8'($random(seed));
		wh_write(IO_BASE + floppy_pkg::PORT_SPDR, b);
		wh_read(IO_BASE + floppy_pkg::PORT_SPSR, v);
		check_value("spi busy", 8'h01, v);
		wait_io_clear(IO_BASE + floppy_pkg::PORT_SPSR, "spi busy");
		wh_read(IO_BASE + floppy_pkg::PORT_SPDR, v);
		check_value("spi loopback", b, v);
		wh_write(IO_BASE + floppy_pkg::PORT_MMCA, 8'h01);
		check_value("card select high", 8'h01, {7'b0, sd_cs});

		// uart frame
		b = 8'($random(seed));
		fork
			decode_uart(rx);
			begin
				wh_write(IO_BASE + floppy_pkg::PORT_TXD, b);
				wh_read(IO_BASE + floppy_pkg::PORT_CTL, v);
				check_value("uart busy", 8'h01, v);
			end
		join
		check_value("uart frame", b, rx);
		wait_io_clear(IO_BASE + floppy_pkg::PORT_CTL, "uart busy");

		// timers
		n1 = 8'd10 + 8'($random(seed) & 8'h1F);
		wh_write(IO_BASE + floppy_pkg::PORT_TMR2, 8'd200);
		wh_write(IO_BASE + floppy_pkg::PORT_TMR1, n1);
		b = n1;
		elapsed = 0;
		do begin
			wh_read(IO_BASE + floppy_pkg::PORT_TMR1, v);
			elapsed++;
			assert (v <= b)
				else abort_run("timer 1 count went up");
			b = v;
			if (elapsed > n1 * TICK_DIV + 8)
				abort_run("timer 1 did not reach zero in time");
		end while (v != 8'h00);
		wh_read(IO_BASE + floppy_pkg::PORT_TMR2, t2);
		assert (t2 > 8'd0 && t2 < 8'd200)
			else abort_run("timer 2 did not count on its own");

		// read sector
		trk = 8'($random(seed));
		sec = 8'($random(seed));
		host_write(floppy_pkg::HREG_TRACK, trk);
		host_write(floppy_pkg::HREG_SECTOR, sec);
		host_write(floppy_pkg::HREG_CMD, 8'h88);
		host_read(floppy_pkg::HREG_CMD, v);
		check_value("read busy", 8'h01, v & 8'h01);
		wait_request(req);
		check_value("read request", 8'h88, req);
		wh_read(IO_BASE + floppy_pkg::PORT_TRACK, v);
		check_value("read track", trk, v);
		wh_read(IO_BASE + floppy_pkg::PORT_SECTOR, v);
		check_value("read sector", sec, v);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			fill[i] = 8'($random(seed));
			wh_write(floppy_pkg::BUF_BASE + 16'(i), fill[i]);
		end
		wh_write(IO_BASE + floppy_pkg::PORT_CPU_STATUS, 8'h5F);
		wait_host_status(8'h02, 8'h02, "drq for read data");
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			host_read_data(v);
			check_value($sformatf("read data %0d", i), fill[i], v);
		end
		host_read(floppy_pkg::HREG_CMD, v);
		check_value("read final status", 8'h5C, v);
		wh_read(IO_BASE + floppy_pkg::PORT_CPU_REQUEST, v);
		check_value("read request cleared", 8'h00, v);

		// write sector
		host_write(floppy_pkg::HREG_CMD, 8'hA0);
		host_read(floppy_pkg::HREG_CMD, v);
		check_value("write busy and drq", 8'h03, v & 8'h03);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			fill[i] = 8'($random(seed));
			host_write(floppy_pkg::HREG_DATA, fill[i]);
		end
		wait_request(req);
		check_value("write request", 8'hA0, req);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			wh_read(floppy_pkg::BUF_BASE + 16'(i), v);
			check_value($sformatf("write data %0d", i), fill[i], v);
		end
		wh_write(IO_BASE + floppy_pkg::PORT_CPU_STATUS, 8'h00);
		wait_host_status(8'h01, 8'h00, "busy clear after write");

		// seek goes out at once
		host_write(floppy_pkg::HREG_CMD, 8'h10);
		wait_request(req);
		check_value("seek request", 8'h10, req);
		host_read(floppy_pkg::HREG_CMD, v);
		check_value("seek busy", 8'h01, v & 8'h01);
		wh_write(IO_BASE + floppy_pkg::PORT_CPU_STATUS, 8'h24);
		wait_host_status(8'h01, 8'h00, "busy clear after seek");
		host_read(floppy_pkg::HREG_CMD, v);
		check_value("seek status", 8'h24, v);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
design/floppy_pkg.sv
design/sector_buffer.sv
design/fdc_host_regs.sv
design/spi_master.sv
design/uart_tx.sv
design/tick_timer.sv
design/floppy_controller.sv
testbench/floppy_tb.sv

//--- Bender.yml
package:
  name: floppy_controller

sources:
  - files:
      - design/floppy_pkg.sv
      - design/sector_buffer.sv
      - design/fdc_host_regs.sv
      - design/spi_master.sv
      - design/uart_tx.sv
      - design/tick_timer.sv
      - design/floppy_controller.sv

  - target: test
    files:
      - testbench/floppy_tb.sv

# testbench top: floppy_tb
# design top: floppy_controller
